// ==== sim/lpif_testdata.hex ====
// Lines 0 and 1 hold delay_x and delay_y
// Then 16 stream records, 89 bits as state protid data dvalid crc crc_valid valid
6
3
1DEADBEEF0123456789ABCD
0CAFEF00D13579BDF02468A
15A5A5A5A0F0F0F0F3C3C3C
0123456789ABCDEF0123456
1FEDCBA9876543210FEDCBA
00000000000000000000001
1FFFFFFFFFFFFFFFFFFFFFF
0AAAAAAAAAAAAAAAAAAAAAA
15555555555555555555555
08000000000000000000000
13141592653589793238462
02718281828459045235360
1C0FFEE00BADC0DE0000FFF
00F1E2D3C4B5A6978879695
1123581321345589144233A
07E57DA7A0000DEAD00BEEF

// ==== verilog.f ====
common/lpif_pkg.sv
hdl/lpif_auto_sync.sv
hdl/lpif_cfg_regs.sv
hdl/lpif_field_map.sv
lpif_stripe/lpif_stripe_tx.sv
lpif_stripe/lpif_stripe_rx.sv
hdl/lpif_link_top.sv
sim/lpif_link_tb.sv

// ==== Makefile ====
# Verilator build and run for the LPIF link testbench

VERILATOR ?= verilator
TOP       ?= lpif_link_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/lpif_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_link_tb;

  import lpif_pkg::*;

  localparam int NUM_CH = 4;
  localparam int N_REC  = 16;

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online;
  logic                    rx_online;
  lpif_strm_t              dstrm;
  lpif_strm_t              ustrm;
  lpif_ch_t [NUM_CH-1:0]   tx_phy;
  lpif_ch_t [NUM_CH-1:0]   rx_phy;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [1:0]              wb_adr;
  logic [31:0]             wb_dat_w;
  logic [31:0]             wb_dat_r;
  logic                    wb_ack;

  // Lines 0 and 1 hold delays and the records follow
  logic [91:0]             tdata [0:N_REC+1];
  logic                    loaded;
  logic                    inj;
  int                      dx_cfg;
  int                      dy_cfg;
  int                      err_cnt;
  int                      test_start_err;
  int                      pass_tests;
  int                      fail_tests;
  int                      tx_high_edges = 0;
  lpif_strm_t              got_ustrm [N_REC+1];
  lpif_ch_t [NUM_CH-1:0]   got_phy [N_REC+1];

  lpif_link_top #(.NUM_CH(NUM_CH)) UUT (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .dstrm     (dstrm),
    .ustrm     (ustrm),
    .tx_phy    (tx_phy),
    .rx_phy    (rx_phy),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

  always #20 clk_wr = ~clk_wr;

  //////////////////////////////
  // PHY loopback
  //////////////////////////////

  // Channel 2 marker flipped while inj is high
  always_comb begin
    rx_phy           = tx_phy;
    rx_phy[2].marker = tx_phy[2].marker ^ inj;
  end

  // Edges that see transmit requested online
  always @(posedge clk_wr) begin
    if (tx_online) tx_high_edges++;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic lpif_strm_t rec_at(input int i);
    rec_at = tdata[i+2][LINK_W-1:0];
  endfunction

  // Link word from the file, zero above LINK_W, channel ch from bit ch*CH_PAYLOAD_W
  function automatic logic [CH_PAYLOAD_W-1:0] chan_payload(input int i, input int ch);
    logic [NUM_CH*CH_PAYLOAD_W-1:0] word;
    word             = '0;
    word[LINK_W-1:0] = tdata[i+2][LINK_W-1:0];
    chan_payload     = word[ch*CH_PAYLOAD_W +: CH_PAYLOAD_W];
  endfunction

  task automatic check_val(input string name, input logic [127:0] exp,
                           input logic [127:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %0h got %0h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_start_err) begin
      pass_tests++;
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, err_cnt - test_start_err);
    end
    test_start_err = err_cnt;
  endtask

  // Called and returns 2 ns after an edge
  task automatic wb_xfer(input logic we, input logic [1:0] adr,
                         input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(posedge clk_wr);
    #2;
    n = 1;
    while (!wb_ack && n < 8) begin
      @(posedge clk_wr);
      #2;
      n++;
    end
    assert (wb_ack) else begin
      $display("Wishbone ack never came for address %0d", adr);
      err_cnt++;
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read_check(input logic [1:0] adr, input logic [31:0] exp,
                               input string name);
    logic [31:0] rd;
    wb_xfer(1'b0, adr, 32'd0, rd);
    check_val(name, 128'(exp), 128'(rd));
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (N_REC + dx_cfg + dy_cfg + 100) * 40;
    #(limit_ns);
    $display("Timeout, run did not finish within %0d ns", limit_ns);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int          idle;
    int          zero_cnt;
    logic [31:0] rd;
    clk_wr         = 1'b0;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    dstrm          = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = 2'd0;
    wb_dat_w       = 32'd0;
    inj            = 1'b0;
    err_cnt        = 0;
    test_start_err = 0;
    pass_tests     = 0;
    fail_tests     = 0;
    $readmemh("sim/lpif_testdata.hex", tdata);
    dx_cfg = int'(tdata[0][15:0]);
    dy_cfg = int'(tdata[1][15:0]);
    loaded = 1'b1;
    void'($urandom(32'h63d2));

    // Reset defaults
    repeat (8) @(posedge clk_wr);
    #2;
    rst_n = 1'b1;
    check_val("wb_ack", 128'd0, 128'(wb_ack));
    check_val("ustrm", 128'd0, 128'(ustrm));
    check_val("tx_phy", 128'd0, 128'(tx_phy));
    wb_read_check(REG_DELAY_X, 32'd4, "wb_dat_r delay_x");
    wb_read_check(REG_DELAY_Y, 32'd2, "wb_dat_r delay_y");
    end_test("reset defaults");

    // New delays and then both directions up together
    wb_xfer(1'b1, REG_DELAY_X, 32'(dx_cfg), rd);
    wb_xfer(1'b1, REG_DELAY_Y, 32'(dy_cfg), rd);
    wb_read_check(REG_DELAY_X, 32'(dx_cfg), "wb_dat_r delay_x");
    wb_read_check(REG_DELAY_Y, 32'(dy_cfg), "wb_dat_r delay_y");
    dstrm     = rec_at(0);
    tx_online = 1'b1;
    rx_online = 1'b1;
    zero_cnt  = 0;
    @(posedge clk_wr);
    #2;
    while (tx_phy == '0 && zero_cnt < 300) begin
      zero_cnt++;
      @(posedge clk_wr);
      #2;
    end
    // delay_x to tx_online_delay plus one for the PHY register
    check_val("tx_phy zero cycles", 128'(dx_cfg + 1), 128'(zero_cnt));
    zero_cnt = 0;
    while (ustrm == '0 && zero_cnt < 300) begin
      zero_cnt++;
      @(posedge clk_wr);
      #2;
    end
    // delay_y after tx_online_delay is seen plus the rx link register
    check_val("ustrm zero cycles", 128'(dy_cfg + 1), 128'(zero_cnt));
    end_test("config and bring-up");

    // One record per cycle
    for (int i = 0; i <= N_REC; i++) begin
      if (i < N_REC) dstrm = rec_at(i);
      @(posedge clk_wr);
      #2;
      got_ustrm[i] = ustrm;
      got_phy[i]   = tx_phy;
    end
    // Two edges from dstrm to ustrm
    for (int i = 0; i < N_REC; i++) begin
      check_val($sformatf("ustrm record %0d", i), 128'(rec_at(i)), 128'(got_ustrm[i+1]));
    end
    // One edge from dstrm to the striped PHY word
    for (int i = 0; i < N_REC; i++) begin
      for (int c = 0; c < NUM_CH; c++) begin
        check_val($sformatf("tx_phy[%0d].payload record %0d", c, i),
                  128'(chan_payload(i, c)), 128'(got_phy[i][c].payload));
      end
    end
    end_test("record loopback");

    for (int j = 0; j <= N_REC; j++) begin
      for (int c = 0; c < NUM_CH; c++) begin
        check_val($sformatf("tx_phy[%0d].strobe", c), 128'd1, 128'(got_phy[j][c].strobe));
        if (c > 0) begin
          check_val($sformatf("tx_phy[%0d].marker", c), 128'(got_phy[j][0].marker),
                    128'(got_phy[j][c].marker));
        end
      end
      // Marker alternates word to word
      if (j > 0) begin
        check_val("tx_phy[0].marker toggle", 128'(!got_phy[j-1][0].marker),
                  128'(got_phy[j][0].marker));
      end
    end
    end_test("strobe and marker");

    // One damaged word and the next fails its toggle check too
    wb_read_check(REG_RX_STAT, 32'd0, "wb_dat_r rx_marker_err");
    idle = $urandom_range(8, 1);
    $display("marker fault on channel 2 after %0d words", idle);
    repeat (idle) begin
      @(posedge clk_wr);
      #2;
    end
    inj = 1'b1;
    @(posedge clk_wr);
    #2;
    inj = 1'b0;
    repeat (3) begin
      @(posedge clk_wr);
      #2;
    end
    wb_read_check(REG_RX_STAT, 32'd2, "wb_dat_r rx_marker_err");
    end_test("marker error count");

    // Drop transmit
    tx_online = 1'b0;
    @(posedge clk_wr);
    #2;
    @(posedge clk_wr);
    #2;
    check_val("tx_phy", 128'd0, 128'(tx_phy));
    @(posedge clk_wr);
    #2;
    check_val("ustrm", 128'd0, 128'(ustrm));
    // Words start delay_x edges in and the first low edge still sends one
    wb_read_check(REG_TX_STAT, 32'(tx_high_edges - dx_cfg), "wb_dat_r tx_word_count");
    repeat (3) begin
      @(posedge clk_wr);
      #2;
    end
    wb_read_check(REG_TX_STAT, 32'(tx_high_edges - dx_cfg), "wb_dat_r tx_word_count");
    end_test("offline and word count");

    $display("tests ok %0d, with errors %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/lpif_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_link_top #(
  parameter int NUM_CH = 4
) (
  input  logic                             clk_wr,
  input  logic                             rst_n,
  input  logic                             tx_online,
  input  logic                             rx_online,
  input  lpif_pkg::lpif_strm_t             dstrm,
  output lpif_pkg::lpif_strm_t             ustrm,
  output lpif_pkg::lpif_ch_t [NUM_CH-1:0]  tx_phy,
  input  lpif_pkg::lpif_ch_t [NUM_CH-1:0]  rx_phy,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [1:0]                       wb_adr,
  input  logic [31:0]                      wb_dat_w,
  output logic [31:0]                      wb_dat_r,
  output logic                             wb_ack
);

  import lpif_pkg::*;

  //////////////////////////////
  // Interconnect
  //////////////////////////////

  logic [15:0]       delay_x;
  logic [15:0]       delay_y;
  logic              tx_online_delay;
  logic              rx_online_delay;
  logic              strobe_bit;
  logic              marker_bit;
  logic [LINK_W-1:0] link_tx;
  logic [LINK_W-1:0] link_rx;
  logic [31:0]       tx_word_count;
  logic [31:0]       rx_marker_err;
  lpif_dbg_t         dbg;

  assign dbg.tx_word_count = tx_word_count;
  assign dbg.rx_marker_err = rx_marker_err;

  //////////////////////////////
  // Sync and config
  //////////////////////////////

  lpif_auto_sync u_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x         (delay_x),
    .delay_y         (delay_y),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .strobe_bit      (strobe_bit),
    .marker_bit      (marker_bit)
  );

  lpif_cfg_regs u_cfg (
    .clk_wr   (clk_wr),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .dbg      (dbg),
    .delay_x  (delay_x),
    .delay_y  (delay_y)
  );

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  lpif_field_map #(.strm_t(lpif_strm_t), .UNPACK(1'b0)) u_map_tx (
    .rec_in   (dstrm),
    .link_in  ('0),
    .rec_out  (),
    .link_out (link_tx)
  );

  lpif_stripe_tx #(.NUM_CH(NUM_CH)) u_stripe_tx (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .online     (tx_online_delay),
    .strobe_bit (strobe_bit),
    .marker_bit (marker_bit),
    .link       (link_tx),
    .tx_phy     (tx_phy),
    .word_count (tx_word_count)
  );

  //////////////////////////////
  // Receive path
  //////////////////////////////

  lpif_stripe_rx #(.NUM_CH(NUM_CH)) u_stripe_rx (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .online     (rx_online_delay),
    .rx_phy     (rx_phy),
    .link       (link_rx),
    .marker_err (rx_marker_err)
  );

  lpif_field_map #(.strm_t(lpif_strm_t), .UNPACK(1'b1)) u_map_rx (
    .rec_in   ('0),
    .link_in  (link_rx),
    .rec_out  (ustrm),
    .link_out ()
  );

endmodule

`default_nettype wire

// ==== lpif_stripe/lpif_stripe_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_stripe_rx #(
  parameter int NUM_CH = 4
) (
  input  logic                             clk_wr,
  input  logic                             rst_n,
  input  logic                             online,
  input  lpif_pkg::lpif_ch_t [NUM_CH-1:0]  rx_phy,
  output logic [lpif_pkg::LINK_W-1:0]      link,
  output logic [31:0]                      marker_err
);

  import lpif_pkg::*;

  localparam int PAD_W = NUM_CH * CH_PAYLOAD_W;

  logic [PAD_W-1:0]  link_pad;
  logic [NUM_CH-1:0] mrk;
  logic [NUM_CH-1:0] stb;
  logic [NUM_CH-1:0] prev_mrk;
  logic              have_ref;
  logic              word_err;

  //////////////////////////////
  // Merge payloads
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      link_pad[i*CH_PAYLOAD_W +: CH_PAYLOAD_W] = rx_phy[i].payload;
      mrk[i] = rx_phy[i].marker;
      stb[i] = rx_phy[i].strobe;
    end
  end

  // Bad word when strobe is low, markers differ or any channel did not toggle
  assign word_err = ~(&stb)
                  | ~((&mrk) | ~(|mrk))
                  | (have_ref & (mrk != ~prev_mrk));

  //////////////////////////////
  // Link register and checks
  //////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      link       <= '0;
      prev_mrk   <= '0;
      have_ref   <= 1'b0;
      marker_err <= '0;
    end else if (online) begin
      link     <= link_pad[LINK_W-1:0];
      // Per-channel reference for the toggle check
      prev_mrk <= mrk;
      have_ref <= 1'b1;
      if (word_err) begin
        marker_err <= marker_err + 32'd1;
      end
    end else begin
      // No checks while offline and the next word re-seeds the reference
      link     <= '0;
      have_ref <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== lpif_stripe/lpif_stripe_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_stripe_tx #(
  parameter int NUM_CH = 4
) (
  input  logic                             clk_wr,
  input  logic                             rst_n,
  input  logic                             online,
  input  logic                             strobe_bit,
  input  logic                             marker_bit,
  input  logic [lpif_pkg::LINK_W-1:0]      link,
  output lpif_pkg::lpif_ch_t [NUM_CH-1:0]  tx_phy,
  output logic [31:0]                      word_count
);

  import lpif_pkg::*;

  // Total payload across all channels
  localparam int PAD_W = NUM_CH * CH_PAYLOAD_W;

  logic [PAD_W-1:0]        link_pad;
  lpif_ch_t [NUM_CH-1:0]   ch_nxt;

  //////////////////////////////
  // Slice link word
  //////////////////////////////

  // Spare top bits go out as zero
  assign link_pad = PAD_W'(link);

  // Channel i takes bits i*CH_PAYLOAD_W upward
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      ch_nxt[i].strobe  = strobe_bit;
      ch_nxt[i].marker  = marker_bit;
      ch_nxt[i].payload = link_pad[i*CH_PAYLOAD_W +: CH_PAYLOAD_W];
    end
  end

  //////////////////////////////
  // PHY register
  //////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy     <= '0;
      word_count <= '0;
    end else if (online) begin
      tx_phy     <= ch_nxt;
      // One word per online cycle
      word_count <= word_count + 32'd1;
    end else begin
      // Quiet link while offline
      tx_phy     <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lpif_field_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_field_map #(
  parameter type strm_t = lpif_pkg::lpif_strm_t,
  parameter bit  UNPACK = 1'b0
) (
  input  strm_t                       rec_in,
  input  logic [lpif_pkg::LINK_W-1:0] link_in,
  output strm_t                       rec_out,
  output logic [lpif_pkg::LINK_W-1:0] link_out
);

  //////////////////////////////
  // Record <-> link word
  //////////////////////////////

  // Fixed order from the MSB down is state, protid, data, dvalid, crc, crc_valid, valid
  if (UNPACK) begin : g_unpack
    always_comb begin
      {rec_out.state,
       rec_out.protid,
       rec_out.data,
       rec_out.dvalid,
       rec_out.crc,
       rec_out.crc_valid,
       rec_out.valid} = link_in;
    end
    // Pack side idle in this direction
    assign link_out = '0;
  end else begin : g_pack
    assign link_out = {rec_in.state,
                       rec_in.protid,
                       rec_in.data,
                       rec_in.dvalid,
                       rec_in.crc,
                       rec_in.crc_valid,
                       rec_in.valid};
    // Unpack side idle in this direction
    assign rec_out  = '0;
  end

endmodule

`default_nettype wire

// ==== hdl/lpif_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_cfg_regs (
  input  logic               clk_wr,
  input  logic               rst_n,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [1:0]         wb_adr,
  input  logic [31:0]        wb_dat_w,
  output logic [31:0]        wb_dat_r,
  output logic               wb_ack,
  input  lpif_pkg::lpif_dbg_t dbg,
  output logic [15:0]        delay_x,
  output logic [15:0]        delay_y
);

  import lpif_pkg::*;

  //////////////////////////////
  // Wishbone classic slave
  //////////////////////////////

  // New request not yet acked
  logic req;

  assign req = wb_cyc & wb_stb & ~wb_ack;

  // Single-cycle ack and delay registers
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack  <= 1'b0;
      delay_x <= 16'd4;
      delay_y <= 16'd2;
    end else begin
      wb_ack <= req;
      if (req && wb_we) begin
        case (wb_adr)
          REG_DELAY_X: delay_x <= wb_dat_w[15:0];
          REG_DELAY_Y: delay_y <= wb_dat_w[15:0];
          // Status registers are read only
          default: ;
        endcase
      end
    end
  end

  // Read data valid with ack
  always_ff @(posedge clk_wr) begin
    if (req && !wb_we) begin
      case (wb_adr)
        REG_DELAY_X: wb_dat_r <= {16'd0, delay_x};
        REG_DELAY_Y: wb_dat_r <= {16'd0, delay_y};
        REG_TX_STAT: wb_dat_r <= dbg.tx_word_count;
        REG_RX_STAT: wb_dat_r <= dbg.rx_marker_err;
        default:     wb_dat_r <= 32'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lpif_auto_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module lpif_auto_sync (
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x,
  input  logic [15:0] delay_y,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        strobe_bit,
  output logic        marker_bit
);

  //////////////////////////////
  // Per-direction delay
  //////////////////////////////

  // Index 0 is transmit and index 1 is receive
  logic        cond [2];
  logic [15:0] dly [2];
  logic        on_q [2];
  logic        marker_q;

  // Receive waits for transmit to be up as well
  assign cond[0] = tx_online;
  assign cond[1] = rx_online & on_q[0];
  assign dly[0]  = delay_x;
  assign dly[1]  = delay_y;

  for (genvar d = 0; d < 2; d++) begin : g_dir
    logic        armed;
    logic [15:0] cnt;

    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        armed   <= 1'b0;
        cnt     <= '0;
        on_q[d] <= 1'b0;
      end else if (!cond[d]) begin
        // Drop at once when the condition is seen low
        armed   <= 1'b0;
        cnt     <= '0;
        on_q[d] <= 1'b0;
      end else if (!armed) begin
        // Load delay on first edge with condition high
        armed   <= 1'b1;
        cnt     <= dly[d];
        on_q[d] <= (dly[d] == 16'd0);
      end else if (cnt != 16'd0) begin
        cnt     <= cnt - 16'd1;
        on_q[d] <= (cnt == 16'd1);
      end
    end
  end

  //////////////////////////////
  // Strobe and marker
  //////////////////////////////

  // Marker held at 0 while offline so the first online word carries 0
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      marker_q <= 1'b0;
    end else if (on_q[0]) begin
      marker_q <= ~marker_q;
    end else begin
      marker_q <= 1'b0;
    end
  end

  assign tx_online_delay = on_q[0];
  assign rx_online_delay = on_q[1];
  // Strobe on every online word
  assign strobe_bit      = on_q[0];
  assign marker_bit      = marker_q;

endmodule

`default_nettype wire

// ==== common/lpif_pkg.sv ====
`default_nettype none

package lpif_pkg;

  //////////////////////////////
  // Stream record
  //////////////////////////////

  // Field order fixes the link word layout from the MSB down
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [15:0] crc;
    logic        crc_valid;
    logic        valid;
  } lpif_strm_t;

  // Flattened link word with one record per cycle
  localparam int LINK_W = $bits(lpif_strm_t);

  //////////////////////////////
  // PHY channel word
  //////////////////////////////

  localparam int CH_PAYLOAD_W = 23;

  typedef struct packed {
    logic                    strobe;
    logic                    marker;
    logic [CH_PAYLOAD_W-1:0] payload;
  } lpif_ch_t;

  // Debug counters seen by the register block
  typedef struct packed {
    logic [31:0] tx_word_count;
    logic [31:0] rx_marker_err;
  } lpif_dbg_t;

  // Wishbone word addresses
  localparam logic [1:0] REG_DELAY_X = 2'd0;
  localparam logic [1:0] REG_DELAY_Y = 2'd1;
  localparam logic [1:0] REG_TX_STAT = 2'd2;
  localparam logic [1:0] REG_RX_STAT = 2'd3;

endpackage

`default_nettype wire
